/* pipePkg.sv */
package pipePkg;

    typedef logic [31:0] word_t;   // data or address word
    typedef logic [4:0]  regAddr_t;

    localparam word_t RESET_VECTOR_DEFAULT = 32'hbfc0_0000;

    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opXor  = 4'd4,
        opNor  = 4'd5,
        opSlt  = 4'd6,
        opSltu = 4'd7,
        opLui  = 4'd8
    } aluOp_e;

    // operand source in decode
    typedef enum logic [1:0] {
        fwdReg = 2'd0,
        fwdEx  = 2'd1,
        fwdWb  = 2'd2
    } fwdSel_e;

    typedef struct packed {
        aluOp_e   aluOp;
        logic     useImm;     // operand b from the immediate
        logic     regWrite;
        logic     isBranch;
        logic     branchNe;   // bne when set, beq otherwise
        regAddr_t writeReg;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_t ctrl;
        word_t srcA;
        word_t srcB;      // already muxed with the immediate
        word_t rtValue;   // forwarded rt for the branch compare
        word_t imm;
    } idEx_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     regWrite;
        regAddr_t writeReg;
        word_t    result;
    } exWb_t;

endpackage

/* regFile.sv */
`timescale 1ns/1ns
module regFile (
    input  logic              clk,
    input  logic              rstN_i,
    input  logic              we_i,
    input  pipePkg::regAddr_t waddr_i,
    input  pipePkg::word_t    wdata_i,
    input  pipePkg::regAddr_t raddrA_i,
    input  pipePkg::regAddr_t raddrB_i,
    output pipePkg::word_t    rdataA_o,
    output pipePkg::word_t    rdataB_o
);
    import pipePkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin   // $0 never changes
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdataA_o = (raddrA_i == '0) ? '0 : regs[raddrA_i];
    assign rdataB_o = (raddrB_i == '0) ? '0 : regs[raddrB_i];

    // writeback address must resolve to one of the 32 registers
    wAddrKnown: assert property (@(posedge clk) disable iff (!rstN_i)
        we_i |-> !$isunknown(waddr_i));

endmodule

/* instDecoder.sv */
`timescale 1ns/1ns
module instDecoder (
    input  pipePkg::word_t instr_i,
    output pipePkg::ctrl_t ctrl_o,
    output pipePkg::word_t imm_o
);
    import pipePkg::*;

    logic [5:0] opcode, funct;
    regAddr_t   rt, rd;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];
    assign rt     = instr_i[20:16];
    assign rd     = instr_i[15:11];

    // andi/ori/xori/lui zero extend, the rest sign extend
    assign imm_o = (opcode[3:2] == 2'b11) ? {16'h0, instr_i[15:0]}
                                          : {{16{instr_i[15]}}, instr_i[15:0]};

    always_comb begin
        ctrl_o = '0;   // unknown words write nothing
        case (opcode)
            6'h00: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.writeReg = rd;
                case (funct)
                    6'h21: ctrl_o.aluOp = opAdd;
                    6'h23: ctrl_o.aluOp = opSub;
                    6'h24: ctrl_o.aluOp = opAnd;
                    6'h25: ctrl_o.aluOp = opOr;
                    6'h26: ctrl_o.aluOp = opXor;
                    6'h27: ctrl_o.aluOp = opNor;
                    6'h2a: ctrl_o.aluOp = opSlt;
                    6'h2b: ctrl_o.aluOp = opSltu;
                    default: ctrl_o.regWrite = 1'b0;   // covers the sll nop
                endcase
            end
            6'h04, 6'h05: begin
                ctrl_o.isBranch = 1'b1;
                ctrl_o.branchNe = opcode[0];
            end
            6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.useImm   = 1'b1;
                ctrl_o.writeReg = rt;   // i-type targets rt
                case (opcode)
                    6'h09:   ctrl_o.aluOp = opAdd;
                    6'h0a:   ctrl_o.aluOp = opSlt;
                    6'h0c:   ctrl_o.aluOp = opAnd;
                    6'h0d:   ctrl_o.aluOp = opOr;
                    6'h0e:   ctrl_o.aluOp = opXor;
                    default: ctrl_o.aluOp = opLui;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* fetchStage.sv */
`timescale 1ns/1ns
module fetchStage #(
    parameter pipePkg::word_t RESET_VECTOR = pipePkg::RESET_VECTOR_DEFAULT
) (
    input  logic           clk,
    input  logic           rstN_i,
    input  logic           flushD_i,
    input  logic           branchTaken_i,
    input  pipePkg::word_t branchTarget_i,
    input  pipePkg::word_t instrF_i,
    output pipePkg::word_t pcF_o,
    output logic           instEnF_o,
    output pipePkg::word_t instrD_o,
    output pipePkg::word_t pcD_o,
    output logic           validD_o
);
    import pipePkg::*;

    word_t pcQ;
    logic  fetchEnQ;   // low for the first cycle out of reset

    assign pcF_o     = pcQ;
    assign instEnF_o = fetchEnQ & ~flushD_i;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcQ      <= RESET_VECTOR;
            fetchEnQ <= 1'b0;
        end else begin
            fetchEnQ <= 1'b1;
            if (branchTaken_i) begin
                pcQ <= branchTarget_i;   // redirect wins over stepping
            end else if (fetchEnQ) begin
                pcQ <= pcQ + 32'd4;
            end
        end
    end

    // fetch/decode register, a disabled fetch turns into sll $0
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            instrD_o <= '0;
            pcD_o    <= '0;
            validD_o <= 1'b0;
        end else begin
            instrD_o <= instEnF_o ? instrF_i : '0;
            pcD_o    <= pcQ;
            validD_o <= instEnF_o;
        end
    end

    // reset vector and branch targets are both word multiples
    pcAligned: assert property (@(posedge clk) disable iff (!rstN_i)
        pcQ[1:0] == 2'b00);

endmodule

/* decodeStage.sv */
`timescale 1ns/1ns
module decodeStage (
    input  logic              clk,
    input  logic              rstN_i,
    input  pipePkg::word_t    instrD_i,
    input  pipePkg::word_t    pcD_i,
    input  logic              validD_i,
    input  logic              flushD_i,
    input  pipePkg::fwdSel_e  fwdA_i,
    input  pipePkg::fwdSel_e  fwdB_i,
    input  pipePkg::word_t    exFwd_i,
    input  pipePkg::word_t    wbFwd_i,
    input  logic              wbWrite_i,
    input  pipePkg::regAddr_t wbReg_i,
    input  pipePkg::word_t    wbData_i,
    output pipePkg::regAddr_t rsD_o,
    output pipePkg::regAddr_t rtD_o,
    output pipePkg::idEx_t    idEx_o
);
    import pipePkg::*;

    ctrl_t ctrlD;
    word_t immD;
    word_t rsReg, rtReg;
    word_t rsVal, rtVal;

    assign rsD_o = instrD_i[25:21];
    assign rtD_o = instrD_i[20:16];

    instDecoder decoder_i (.instr_i(instrD_i), .ctrl_o(ctrlD), .imm_o(immD));

    regFile rf_i (
        .clk(clk), .rstN_i(rstN_i),
        .we_i(wbWrite_i), .waddr_i(wbReg_i), .wdata_i(wbData_i),
        .raddrA_i(rsD_o), .raddrB_i(rtD_o), .rdataA_o(rsReg), .rdataB_o(rtReg)
    );

    function automatic word_t pickOperand(input fwdSel_e sel, input word_t regVal);
        word_t val;
        case (sel)
            fwdEx:   val = exFwd_i;
            fwdWb:   val = wbFwd_i;
            default: val = regVal;
        endcase
        return val;
    endfunction

    always_comb begin
        rsVal = pickOperand(fwdA_i, rsReg);
        rtVal = pickOperand(fwdB_i, rtReg);
    end

    // decode/execute register
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            idEx_o <= '0;
        end else if (flushD_i || !validD_i) begin
            idEx_o <= '0;   // bubble
        end else begin
            idEx_o.valid   <= 1'b1;
            idEx_o.pc      <= pcD_i;
            idEx_o.ctrl    <= ctrlD;
            idEx_o.srcA    <= rsVal;
            idEx_o.srcB    <= ctrlD.useImm ? immD : rtVal;
            idEx_o.rtValue <= rtVal;
            idEx_o.imm     <= immD;
        end
    end

endmodule

/* executeStage.sv */
`timescale 1ns/1ns
module executeStage (
    input  logic           clk,
    input  logic           rstN_i,
    input  pipePkg::idEx_t idEx_i,
    output pipePkg::word_t exFwd_o,
    output logic           branchTaken_o,
    output pipePkg::word_t branchTarget_o,
    output pipePkg::exWb_t exWb_o
);
    import pipePkg::*;

    word_t a, b;
    word_t aluResult;
    logic  srcEq;

    assign a = idEx_i.srcA;
    assign b = idEx_i.srcB;

    always_comb begin
        case (idEx_i.ctrl.aluOp)
            opAdd:   aluResult = a + b;
            opSub:   aluResult = a - b;
            opAnd:   aluResult = a & b;
            opOr:    aluResult = a | b;
            opXor:   aluResult = a ^ b;
            opNor:   aluResult = ~(a | b);
            opSlt:   aluResult = {31'b0, $signed(a) < $signed(b)};
            opSltu:  aluResult = {31'b0, a < b};
            opLui:   aluResult = {b[15:0], 16'h0000};   // imm into upper half
            default: aluResult = '0;
        endcase
    end

    assign exFwd_o = aluResult;   // forwarded to decode same cycle

    // beq/bne on forwarded rs and rt
    assign srcEq          = (idEx_i.srcA == idEx_i.rtValue);
    assign branchTaken_o  = idEx_i.valid & idEx_i.ctrl.isBranch
                          & (srcEq ^ idEx_i.ctrl.branchNe);
    assign branchTarget_o = idEx_i.pc + 32'd4 + {idEx_i.imm[29:0], 2'b00};

    // execute/writeback register
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            exWb_o <= '0;
        end else begin
            exWb_o.valid    <= idEx_i.valid;
            exWb_o.pc       <= idEx_i.pc;
            exWb_o.regWrite <= idEx_i.ctrl.regWrite & ~idEx_i.ctrl.isBranch;
            exWb_o.writeReg <= idEx_i.ctrl.writeReg;
            exWb_o.result   <= aluResult;
        end
    end

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ns
module hazardUnit (
    input  pipePkg::regAddr_t rsD_i,
    input  pipePkg::regAddr_t rtD_i,
    input  pipePkg::exWb_t    exWb_i,
    input  pipePkg::ctrl_t    exCtrl_i,
    input  logic              exValid_i,
    input  logic              branchTaken_i,
    output pipePkg::fwdSel_e  fwdA_o,
    output pipePkg::fwdSel_e  fwdB_o,
    output logic              flushD_o
);
    import pipePkg::*;

    // youngest producer first, $0 always from the file
    function automatic fwdSel_e pickSrc(input regAddr_t src);
        fwdSel_e sel;
        sel = fwdReg;
        if (src != '0) begin
            if (exValid_i && exCtrl_i.regWrite && exCtrl_i.writeReg == src) begin
                sel = fwdEx;
            end else if (exWb_i.valid && exWb_i.regWrite && exWb_i.writeReg == src) begin
                sel = fwdWb;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwdA_o = pickSrc(rsD_i);
        fwdB_o = pickSrc(rtD_i);
    end

    assign flushD_o = branchTaken_i;   // squash fetch and decode

endmodule

/* miniMips.sv */
`timescale 1ns/1ns
module miniMips #(
    parameter pipePkg::word_t RESET_VECTOR = pipePkg::RESET_VECTOR_DEFAULT
) (
    input  logic              clk,
    input  logic              rstN_i,
    output pipePkg::word_t    pcF_o,
    output logic              instEnF_o,
    input  pipePkg::word_t    instrF_i,
    output pipePkg::word_t    debugWbPc_o,
    output logic [3:0]        debugWbRfWen_o,
    output pipePkg::regAddr_t debugWbRfWnum_o,
    output pipePkg::word_t    debugWbRfWdata_o
);
    import pipePkg::*;

    word_t    instrD, pcD;
    logic     validD;
    regAddr_t rsD, rtD;
    idEx_t    idEx;
    exWb_t    exWb;
    word_t    exFwd;
    logic     branchTaken;
    word_t    branchTarget;
    fwdSel_e  fwdA, fwdB;
    logic     flushD;
    logic     wbWrite;

    assign wbWrite = exWb.valid & exWb.regWrite;   // retiring write

    fetchStage #(.RESET_VECTOR(RESET_VECTOR)) fetch_i (
        .clk(clk), .rstN_i(rstN_i), .flushD_i(flushD),
        .branchTaken_i(branchTaken), .branchTarget_i(branchTarget),
        .instrF_i(instrF_i), .pcF_o(pcF_o), .instEnF_o(instEnF_o),
        .instrD_o(instrD), .pcD_o(pcD), .validD_o(validD)
    );

    decodeStage decode_i (
        .clk(clk), .rstN_i(rstN_i),
        .instrD_i(instrD), .pcD_i(pcD), .validD_i(validD), .flushD_i(flushD),
        .fwdA_i(fwdA), .fwdB_i(fwdB), .exFwd_i(exFwd), .wbFwd_i(exWb.result),
        .wbWrite_i(wbWrite), .wbReg_i(exWb.writeReg), .wbData_i(exWb.result),
        .rsD_o(rsD), .rtD_o(rtD), .idEx_o(idEx)
    );

    executeStage execute_i (
        .clk(clk), .rstN_i(rstN_i), .idEx_i(idEx), .exFwd_o(exFwd),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget), .exWb_o(exWb)
    );

    hazardUnit hazard_i (
        .rsD_i(rsD), .rtD_i(rtD), .exWb_i(exWb), .exCtrl_i(idEx.ctrl),
        .exValid_i(idEx.valid), .branchTaken_i(branchTaken),
        .fwdA_o(fwdA), .fwdB_o(fwdB), .flushD_o(flushD)
    );

    // debug writeback port
    assign debugWbPc_o      = exWb.pc;
    assign debugWbRfWen_o   = {4{wbWrite}};
    assign debugWbRfWnum_o  = exWb.writeReg;
    assign debugWbRfWdata_o = exWb.result;

endmodule

/* tbProgram.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

typedef struct packed {
    logic [31:0] instr;
    logic        writes;   // expects a writeback
    logic [4:0]  wReg;
    logic [31:0] wData;
} progEntry_t;

progEntry_t  prog [$];
logic [31:0] rngState = 32'hb3b4;

function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [5:0] funct);
    return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

task automatic addEntry(input logic [31:0] instr, input logic writes,
                        input logic [4:0] wReg, input logic [31:0] wData);
    progEntry_t e;
    e.instr  = instr;
    e.writes = writes;
    e.wReg   = wReg;
    e.wData  = wData;
    prog.push_back(e);
endtask

task automatic loadDirected();
    addEntry(encodeI(6'h0f, 5'd0, 5'd1, 16'h1234), 1'b1, 5'd1, 32'h1234_0000);  // lui
    addEntry(encodeI(6'h0d, 5'd1, 5'd1, 16'h5678), 1'b1, 5'd1, 32'h1234_5678);
    addEntry(encodeI(6'h09, 5'd0, 5'd2, 16'hffff), 1'b1, 5'd2, 32'hffff_ffff);
    addEntry(encodeR(5'd1, 5'd2, 5'd3, 6'h21), 1'b1, 5'd3, 32'h1234_5677);  // wb and ex fwd
    addEntry(encodeR(5'd1, 5'd3, 5'd4, 6'h23), 1'b1, 5'd4, 32'h0000_0001);  // rs from file
    addEntry(encodeR(5'd2, 5'd4, 5'd5, 6'h2a), 1'b1, 5'd5, 32'h0000_0001);
    addEntry(encodeR(5'd2, 5'd4, 5'd6, 6'h2b), 1'b1, 5'd6, 32'h0000_0000);
    addEntry(encodeR(5'd1, 5'd2, 5'd7, 6'h24), 1'b1, 5'd7, 32'h1234_5678);
    addEntry(encodeR(5'd3, 5'd4, 5'd8, 6'h25), 1'b1, 5'd8, 32'h1234_5677);
    addEntry(encodeR(5'd1, 5'd3, 5'd9, 6'h26), 1'b1, 5'd9, 32'h0000_000f);
    addEntry(encodeR(5'd4, 5'd0, 5'd10, 6'h27), 1'b1, 5'd10, 32'hffff_fffe);
    addEntry(encodeI(6'h0a, 5'd0, 5'd11, 16'hffff), 1'b1, 5'd11, 32'h0000_0000);
    addEntry(encodeI(6'h0c, 5'd2, 5'd12, 16'h8f0f), 1'b1, 5'd12, 32'h0000_8f0f);
    addEntry(encodeI(6'h0e, 5'd2, 5'd13, 16'h80ff), 1'b1, 5'd13, 32'hffff_7f00);
    addEntry(encodeI(6'h0d, 5'd0, 5'd14, 16'h8000), 1'b1, 5'd14, 32'h0000_8000);
    addEntry(encodeI(6'h09, 5'd0, 5'd15, 16'h8000), 1'b1, 5'd15, 32'hffff_8000);
    addEntry(encodeI(6'h04, 5'd1, 5'd7, 16'd2), 1'b0, 5'd0, 32'h0);   // beq taken
    addEntry(encodeI(6'h09, 5'd0, 5'd20, 16'h0bad), 1'b0, 5'd0, 32'h0);
    addEntry(encodeI(6'h09, 5'd0, 5'd21, 16'h0bad), 1'b0, 5'd0, 32'h0);
    addEntry(encodeI(6'h05, 5'd1, 5'd1, 16'd5), 1'b0, 5'd0, 32'h0);   // bne not taken
    addEntry(encodeI(6'h09, 5'd0, 5'd16, 16'h0016), 1'b1, 5'd16, 32'h0000_0016);
    addEntry(encodeI(6'h05, 5'd16, 5'd0, 16'd1), 1'b0, 5'd0, 32'h0);  // bne taken
    addEntry(encodeI(6'h09, 5'd0, 5'd22, 16'h0bad), 1'b0, 5'd0, 32'h0);
    addEntry(encodeR(5'd1, 5'd2, 5'd0, 6'h21), 1'b1, 5'd0, 32'h1234_5677);  // into $0
    addEntry(encodeR(5'd0, 5'd1, 5'd17, 6'h21), 1'b1, 5'd17, 32'h1234_5678);
    addEntry(32'h0000_0000, 1'b0, 5'd0, 32'h0);
endtask

// lui/ori/addu/subu/slt on r24..r27 against a shadow register set
task automatic addRandomBlock(input int count);
    logic [31:0] shadow [32];
    logic [31:0] r;
    logic [31:0] word;
    logic [31:0] res;
    logic [4:0]  rs, rt, rd;
    logic [15:0] imm;
    int          sel;
    for (int k = 0; k < 32; k++) begin
        shadow[k] = 32'h0;
    end
    for (int k = 0; k < count; k++) begin
        rngState = xorshift(rngState);
        r   = rngState;
        rs  = {3'b110, r[4:3]};
        rt  = {3'b110, r[6:5]};
        rd  = {3'b110, r[8:7]};
        imm = r[31:16];
        sel = r[15:9] % 5;
        case (sel)
            0: word = encodeI(6'h0f, 5'd0, rd, imm);
            1: word = encodeI(6'h0d, rs, rd, imm);
            2: word = encodeR(rs, rt, rd, 6'h21);
            3: word = encodeR(rs, rt, rd, 6'h23);
            default: word = encodeR(rs, rt, rd, 6'h2a);
        endcase
        case (sel)
            0: res = {imm, 16'h0000};
            1: res = shadow[rs] | {16'h0000, imm};   // ori zero extends
            2: res = shadow[rs] + shadow[rt];
            3: res = shadow[rs] - shadow[rt];
            default: res = ($signed(shadow[rs]) < $signed(shadow[rt])) ? 32'd1 : 32'd0;
        endcase
        shadow[rd] = res;
        addEntry(word, 1'b1, rd, res);
    end
endtask

`endif

/* tbMiniMips.sv */
`timescale 1ns/1ns
module tbMiniMips;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 2;
    localparam int          RANDOM_COUNT = 24;
    localparam logic [31:0] RESET_VECTOR = 32'hbfc0_0000;

    typedef struct packed {
        logic [31:0] wPc;
        logic [4:0]  wReg;
        logic [31:0] wData;
    } expEntry_t;

    logic        clk;
    logic        rstN;
    logic [31:0] pcF;
    logic        instEnF;
    logic [31:0] instrF;
    logic [31:0] wbPc;
    logic [3:0]  wbWen;
    logic [4:0]  wbNum;
    logic [31:0] wbData;

    logic [31:0] imem [$];
    expEntry_t   expQ [$];
    expEntry_t   curExp;
    logic [31:0] fetchIdx;
    int          expIdx;
    int          failCount;
    int          extraCount;
    int          missCount;
    int          cycleCount;
    int          cycleLimit;

    `include "tbProgram.svh"

    miniMips #(.RESET_VECTOR(RESET_VECTOR)) miniMips_i (
        .clk(clk), .rstN_i(rstN), .pcF_o(pcF), .instEnF_o(instEnF), .instrF_i(instrF),
        .debugWbPc_o(wbPc), .debugWbRfWen_o(wbWen), .debugWbRfWnum_o(wbNum),
        .debugWbRfWdata_o(wbData)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // program words into memory, writing entries into the retire list
    task automatic applyTable();
        progEntry_t cur;
        expEntry_t  e;
        for (int i = 0; i < prog.size(); i++) begin
            cur = prog[i];
            imem.push_back(cur.instr);
            if (cur.writes) begin
                e.wPc   = RESET_VECTOR + 32'(i * 4);
                e.wReg  = cur.wReg;
                e.wData = cur.wData;
                expQ.push_back(e);
            end
        end
    endtask

    // instruction memory, nop past the end
    always @(negedge clk) begin
        fetchIdx = (pcF - RESET_VECTOR) >> 2;
        instrF = (fetchIdx < imem.size()) ? imem[fetchIdx] : 32'h0000_0000;
    end

    always @(negedge clk) begin
        if (rstN && wbWen != 4'h0) begin
            if (wbWen !== 4'hf) begin
                $display("[FAIL] %0t: write enable %h, expected f", $time, wbWen);
                failCount++;
            end
            if (expIdx >= expQ.size()) begin
                $display("unexpected writeback at %0t: r%0d = %h from pc %h", $time,
                         wbNum, wbData, wbPc);
                extraCount++;
            end else begin
                curExp = expQ[expIdx];
                if (wbPc !== curExp.wPc || wbNum !== curExp.wReg
                        || wbData !== curExp.wData) begin
                    $display("[FAIL] %0t: wb %0d got pc %h r%0d %h, expected pc %h r%0d %h",
                             $time, expIdx, wbPc, wbNum, wbData,
                             curExp.wPc, curExp.wReg, curExp.wData);
                    failCount++;
                end
                expIdx++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, only %0d of %0d writebacks seen",
                     cycleCount, expIdx, expQ.size());
            $display("errors: %0d wrong, %0d unexpected, %0d missing",
                     failCount, extraCount, expQ.size() - expIdx);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instrF     = 32'h0000_0000;
        expIdx     = 0;
        failCount  = 0;
        extraCount = 0;
        cycleCount = 0;
        loadDirected();
        addRandomBlock(RANDOM_COUNT);
        applyTable();
        cycleLimit = (prog.size() + 20) * 2;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        if (pcF !== RESET_VECTOR || wbWen !== 4'h0 || instEnF !== 1'b0) begin
            $display("[FAIL] %0t: in reset pc %h wen %h fetch enable %b", $time,
                     pcF, wbWen, instEnF);
            failCount++;
        end
        rstN = 1'b1;
        while (expIdx < expQ.size()) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);   // room for stray writebacks
        @(posedge clk);
        missCount = expQ.size() - expIdx;
        if (missCount != 0) begin
            $display("%0d expected writebacks never retired", missCount);
        end
        $display("errors: %0d wrong, %0d unexpected, %0d missing",
                 failCount, extraCount, missCount);
        if (failCount + extraCount + missCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* miniMips.f */
+incdir+.
pipePkg.sv
regFile.sv
instDecoder.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
hazardUnit.sv
miniMips.sv
tbMiniMips.sv

/* Bender.yml */
package:
  name: miniMips

sources:
  - files:
      - pipePkg.sv
      - regFile.sv
      - instDecoder.sv
      - fetchStage.sv
      - decodeStage.sv
      - executeStage.sv
      - hazardUnit.sv
      - miniMips.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbMiniMips.sv
